/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= output_bus_arbiter_tb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, check the log"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
rtl/output_bus_pkg.sv
rtl/bank_cmd_if.sv
rtl/bank_command_router.sv
rtl/bank_busy_tracker.sv
rtl/round_robin_arbiter.sv
rtl/output_bus_arbiter.sv
tests/output_bus_arbiter_props.sv
tests/output_bus_arbiter_tb.sv

/* rtl/bank_busy_tracker.sv */
`default_nettype none

module bank_busy_tracker (
    input  logic clk,
    input  logic reset,
    input  logic [output_bus_pkg::num_edge_pe-1:0] pe_req,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] pe_node_id,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_req,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_eos,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] eb_node_id,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_req,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_eos,
    input  logic [output_bus_pkg::num_vertex_unit-1:0][output_bus_pkg::node_id_w-1:0] vb_node_id,
    input  logic [output_bus_pkg::num_banks-1:0] bank_eos,
    input  logic [output_bus_pkg::num_reqs-1:0] grants,
    output logic [output_bus_pkg::num_reqs-1:0] masked_reqs
);

    localparam int num_streams = output_bus_pkg::num_edge_pe + output_bus_pkg::num_vertex_unit;

    logic [output_bus_pkg::num_reqs-1:0] all_req;
    logic [output_bus_pkg::num_reqs-1:0][output_bus_pkg::node_id_w-1:0] all_node_id;
    logic [num_streams-1:0] st_eos;
    logic [num_streams-1:0][output_bus_pkg::node_id_w-1:0] st_node_id;

    logic [output_bus_pkg::num_banks-1:0] busy;
    logic [output_bus_pkg::num_banks-1:0] nx_busy;
    logic [output_bus_pkg::num_reqs-1:0][output_bus_pkg::bank_w-1:0] cur_bank;
    // bank each requester aimed at last cycle, lines up with grants
    logic [output_bus_pkg::num_reqs-1:0][output_bus_pkg::bank_w-1:0] target_bank;

    assign all_req = {vb_req, eb_req, pe_req};
    assign all_node_id = {vb_node_id, eb_node_id, pe_node_id};
    assign st_eos = {vb_eos, eb_eos};
    assign st_node_id = {vb_node_id, eb_node_id};

    always_comb begin
        nx_busy = busy;
        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            if (grants[i]) begin
                nx_busy[target_bank[i]] = 1'b1;
            end
        end

        // mask against the busy state including this cycle's grant
        for (int i = 0; i < output_bus_pkg::num_reqs; i++) begin
            cur_bank[i] = all_node_id[i][output_bus_pkg::bank_w-1:0];
            masked_reqs[i] = all_req[i] & ~nx_busy[cur_bank[i]];
        end

        // releases land next cycle
        for (int b = 0; b < output_bus_pkg::num_banks; b++) begin
            if (bank_eos[b]) begin
                nx_busy[b] = 1'b0;
            end
        end
        for (int s = 0; s < num_streams; s++) begin
            if (st_eos[s]) begin
                nx_busy[st_node_id[s][output_bus_pkg::bank_w-1:0]] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            busy <= nx_busy;
        end
    end

    always_ff @(posedge clk) begin
        target_bank <= cur_bank;
    end

endmodule

`default_nettype wire

/* rtl/bank_cmd_if.sv */
`default_nettype none

interface bank_cmd_if;

    logic [output_bus_pkg::num_banks-1:0] valid;
    logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::pe_tag_w-1:0] pe_tag;
    // 0 read, 1 write
    logic [output_bus_pkg::num_banks-1:0] rd_wr;
    logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::node_id_w-1:0] node_id;
    logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::data_w-1:0] data;
    logic [output_bus_pkg::num_banks-1:0] wr_sos;
    logic [output_bus_pkg::num_banks-1:0] wr_eos;

    modport source (
        output valid,
        output pe_tag,
        output rd_wr,
        output node_id,
        output data,
        output wr_sos,
        output wr_eos
    );

    modport sink (
        input valid,
        input pe_tag,
        input rd_wr,
        input node_id,
        input data,
        input wr_sos,
        input wr_eos
    );

endinterface

`default_nettype wire

/* rtl/bank_command_router.sv */
`default_nettype none

module bank_command_router (
    input  logic clk,
    input  logic reset,
    input  logic [output_bus_pkg::num_edge_pe-1:0] pe_grant_valid,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::pe_tag_w-1:0] pe_tag,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] pe_node_id,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_grant_valid,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_sos,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_eos,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::data_w-1:0] eb_data,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] eb_node_id,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_grant_valid,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_sos,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_eos,
    input  logic [output_bus_pkg::num_vertex_unit-1:0][output_bus_pkg::data_w-1:0] vb_data,
    input  logic [output_bus_pkg::num_vertex_unit-1:0][output_bus_pkg::node_id_w-1:0] vb_node_id,
    bank_cmd_if.source cmd
);

    localparam int num_streams = output_bus_pkg::num_edge_pe + output_bus_pkg::num_vertex_unit;

    // write streams, edge-bank first so vertex-bank wins a collision
    logic [num_streams-1:0] st_grant_valid;
    logic [num_streams-1:0] st_sos;
    logic [num_streams-1:0] st_eos;
    logic [num_streams-1:0][output_bus_pkg::data_w-1:0] st_data;
    logic [num_streams-1:0][output_bus_pkg::node_id_w-1:0] st_node_id;

    logic [output_bus_pkg::num_banks-1:0] nx_valid;
    logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::pe_tag_w-1:0] nx_pe_tag;
    logic [output_bus_pkg::num_banks-1:0] nx_rd_wr;
    logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::node_id_w-1:0] nx_node_id;
    logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::data_w-1:0] nx_data;
    logic [output_bus_pkg::num_banks-1:0] nx_wr_sos;
    logic [output_bus_pkg::num_banks-1:0] nx_wr_eos;

    assign st_grant_valid = {vb_grant_valid, eb_grant_valid};
    assign st_sos = {vb_sos, eb_sos};
    assign st_eos = {vb_eos, eb_eos};
    assign st_data = {vb_data, eb_data};
    assign st_node_id = {vb_node_id, eb_node_id};

    always_comb begin
        logic [output_bus_pkg::bank_w-1:0] b;
        nx_valid = '0;
        nx_pe_tag = '0;
        nx_rd_wr = '0;
        nx_node_id = '0;
        nx_data = '0;
        nx_wr_sos = '0;
        nx_wr_eos = '0;
        b = '0;
        // reads from edge PEs
        for (int i = 0; i < output_bus_pkg::num_edge_pe; i++) begin
            if (pe_grant_valid[i]) begin
                b = pe_node_id[i][output_bus_pkg::bank_w-1:0];
                nx_valid[b] = 1'b1;
                nx_pe_tag[b] = pe_tag[i];
                nx_rd_wr[b] = 1'b0;
                nx_node_id[b] = pe_node_id[i];
                nx_data[b] = '0;
                nx_wr_sos[b] = 1'b0;
                nx_wr_eos[b] = 1'b0;
            end
        end
        // writes, later index overrides
        for (int s = 0; s < num_streams; s++) begin
            if (st_grant_valid[s]) begin
                b = st_node_id[s][output_bus_pkg::bank_w-1:0];
                nx_valid[b] = 1'b1;
                nx_pe_tag[b] = '0;
                nx_rd_wr[b] = 1'b1;
                nx_node_id[b] = st_node_id[s];
                nx_data[b] = st_data[s];
                nx_wr_sos[b] = st_sos[s];
                nx_wr_eos[b] = st_eos[s];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd.valid <= '0;
            cmd.pe_tag <= '0;
            cmd.rd_wr <= '0;
            cmd.node_id <= '0;
            cmd.data <= '0;
            cmd.wr_sos <= '0;
            cmd.wr_eos <= '0;
        end else begin
            cmd.valid <= nx_valid;
            cmd.pe_tag <= nx_pe_tag;
            cmd.rd_wr <= nx_rd_wr;
            cmd.node_id <= nx_node_id;
            cmd.data <= nx_data;
            cmd.wr_sos <= nx_wr_sos;
            cmd.wr_eos <= nx_wr_eos;
        end
    end

endmodule

`default_nettype wire

/* rtl/output_bus_arbiter.sv */
`default_nettype none

module output_bus_arbiter (
    input  logic clk,
    input  logic reset,

    // edge PE reads
    input  logic [output_bus_pkg::num_edge_pe-1:0] pe_grant_valid,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::pe_tag_w-1:0] pe_tag,
    input  logic [output_bus_pkg::num_edge_pe-1:0] pe_req,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] pe_node_id,

    // edge-bank write streams
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_grant_valid,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_sos,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_eos,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::data_w-1:0] eb_data,
    input  logic [output_bus_pkg::num_edge_pe-1:0] eb_req,
    input  logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] eb_node_id,

    // vertex-bank write streams
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_grant_valid,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_sos,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_eos,
    input  logic [output_bus_pkg::num_vertex_unit-1:0][output_bus_pkg::data_w-1:0] vb_data,
    input  logic [output_bus_pkg::num_vertex_unit-1:0] vb_req,
    input  logic [output_bus_pkg::num_vertex_unit-1:0][output_bus_pkg::node_id_w-1:0] vb_node_id,

    input  logic [output_bus_pkg::num_banks-1:0] bank_eos,

    // per-bank commands
    output logic [output_bus_pkg::num_banks-1:0] bank_valid,
    output logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::pe_tag_w-1:0] bank_pe_tag,
    output logic [output_bus_pkg::num_banks-1:0] bank_rd_wr,
    output logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::node_id_w-1:0] bank_node_id,
    output logic [output_bus_pkg::num_banks-1:0][output_bus_pkg::data_w-1:0] bank_data,
    output logic [output_bus_pkg::num_banks-1:0] bank_wr_sos,
    output logic [output_bus_pkg::num_banks-1:0] bank_wr_eos,

    output logic [output_bus_pkg::num_reqs-1:0] grants
);

    logic [output_bus_pkg::num_reqs-1:0] masked_reqs;

    bank_cmd_if cmd_bus ();

    bank_command_router bank_command_router_inst (
        .clk            (clk),
        .reset          (reset),
        .pe_grant_valid (pe_grant_valid),
        .pe_tag         (pe_tag),
        .pe_node_id     (pe_node_id),
        .eb_grant_valid (eb_grant_valid),
        .eb_sos         (eb_sos),
        .eb_eos         (eb_eos),
        .eb_data        (eb_data),
        .eb_node_id     (eb_node_id),
        .vb_grant_valid (vb_grant_valid),
        .vb_sos         (vb_sos),
        .vb_eos         (vb_eos),
        .vb_data        (vb_data),
        .vb_node_id     (vb_node_id),
        .cmd            (cmd_bus.source)
    );

    bank_busy_tracker bank_busy_tracker_inst (
        .clk         (clk),
        .reset       (reset),
        .pe_req      (pe_req),
        .pe_node_id  (pe_node_id),
        .eb_req      (eb_req),
        .eb_eos      (eb_eos),
        .eb_node_id  (eb_node_id),
        .vb_req      (vb_req),
        .vb_eos      (vb_eos),
        .vb_node_id  (vb_node_id),
        .bank_eos    (bank_eos),
        .grants      (grants),
        .masked_reqs (masked_reqs)
    );

    round_robin_arbiter round_robin_arbiter_inst (
        .clk         (clk),
        .reset       (reset),
        .masked_reqs (masked_reqs),
        .grants      (grants)
    );

    // command bus out to the banks
    assign bank_valid = cmd_bus.valid;
    assign bank_pe_tag = cmd_bus.pe_tag;
    assign bank_rd_wr = cmd_bus.rd_wr;
    assign bank_node_id = cmd_bus.node_id;
    assign bank_data = cmd_bus.data;
    assign bank_wr_sos = cmd_bus.wr_sos;
    assign bank_wr_eos = cmd_bus.wr_eos;

endmodule

`default_nettype wire

/* rtl/output_bus_pkg.sv */
`default_nettype none

package output_bus_pkg;

    // requester groups
    localparam int num_edge_pe = 4;
    localparam int num_vertex_unit = 4;

    // output sram banks
    localparam int num_banks = 4;

    // edge PEs first, then edge-bank streams, then vertex-bank streams
    localparam int num_reqs = 2 * num_edge_pe + num_vertex_unit;

    // bank select is the low bits of the node id
    localparam int bank_w = 2;
    localparam int node_id_w = 8;

    localparam int pe_tag_w = 2;

    // feature vector bus
    localparam int data_w = 32;

    localparam int req_idx_w = 4;

endpackage

`default_nettype wire

/* rtl/round_robin_arbiter.sv */
`default_nettype none

module round_robin_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic [output_bus_pkg::num_reqs-1:0] masked_reqs,
    output logic [output_bus_pkg::num_reqs-1:0] grants
);

    // search starts here
    logic [output_bus_pkg::req_idx_w-1:0] ptr;
    logic [output_bus_pkg::req_idx_w-1:0] nx_ptr;
    logic [output_bus_pkg::num_reqs-1:0] nx_grants;

    always_comb begin
        int cand;
        int nxt;
        logic found;
        nx_grants = '0;
        nx_ptr = ptr;
        found = 1'b0;
        nxt = 0;
        for (int k = 0; k < output_bus_pkg::num_reqs; k++) begin
            cand = int'(ptr) + k;
            if (cand >= output_bus_pkg::num_reqs) begin
                cand = cand - output_bus_pkg::num_reqs;
            end
            if (!found && masked_reqs[cand]) begin
                found = 1'b1;
                nx_grants[cand] = 1'b1;
                // pointer moves just past the winner
                nxt = cand + 1;
                if (nxt == output_bus_pkg::num_reqs) begin
                    nxt = 0;
                end
                nx_ptr = nxt[output_bus_pkg::req_idx_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
            grants <= '0;
        end else begin
            ptr <= nx_ptr;
            grants <= nx_grants;
        end
    end

endmodule

`default_nettype wire

/* tests/output_bus_arbiter_props.sv */
`default_nettype none

module output_bus_arbiter_props (
    input logic clk,
    input logic reset,
    input logic [output_bus_pkg::num_edge_pe-1:0] pe_grant_valid,
    input logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] pe_node_id,
    input logic [output_bus_pkg::num_edge_pe-1:0] eb_grant_valid,
    input logic [output_bus_pkg::num_edge_pe-1:0] eb_eos,
    input logic [output_bus_pkg::num_edge_pe-1:0][output_bus_pkg::node_id_w-1:0] eb_node_id,
    input logic [output_bus_pkg::num_vertex_unit-1:0] vb_grant_valid,
    input logic [output_bus_pkg::num_vertex_unit-1:0] vb_eos,
    input logic [output_bus_pkg::num_vertex_unit-1:0][output_bus_pkg::node_id_w-1:0] vb_node_id,
    input logic [output_bus_pkg::num_banks-1:0] bank_eos,
    input logic [output_bus_pkg::num_banks-1:0] bank_valid,
    input logic [output_bus_pkg::num_reqs-1:0] grants
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int nr = output_bus_pkg::num_reqs;
    localparam int nb = output_bus_pkg::num_banks;

    logic [nr-1:0] gv;
    logic [nr-1:0] eos_all;
    logic [nr-1:0][output_bus_pkg::node_id_w-1:0] node;
    logic [nr-1:0][output_bus_pkg::bank_w-1:0] prev_bank;
    logic [nb-1:0] gv_bank;
    logic [nb-1:0] grant_bank;
    logic [nb-1:0] release_bank;
    // banks held by a grant and not yet released
    logic [nb-1:0] held;

    assign gv = {vb_grant_valid, eb_grant_valid, pe_grant_valid};
    assign eos_all = {vb_eos, eb_eos, {output_bus_pkg::num_edge_pe{1'b0}}};
    assign node = {vb_node_id, eb_node_id, pe_node_id};

    always_comb begin
        gv_bank = '0;
        grant_bank = '0;
        release_bank = bank_eos;
        for (int i = 0; i < nr; i++) begin
            if (gv[i]) begin
                gv_bank[node[i][output_bus_pkg::bank_w-1:0]] = 1'b1;
            end
            if (grants[i]) begin
                grant_bank[prev_bank[i]] = 1'b1;
            end
            if (eos_all[i]) begin
                release_bank[node[i][output_bus_pkg::bank_w-1:0]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < nr; i++) begin
            prev_bank[i] <= node[i][output_bus_pkg::bank_w-1:0];
        end
        if (reset) begin
            held <= '0;
        end else begin
            held <= (held | grant_bank) & ~release_bank;
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(grants))
        else $error("grants has more than one bit set");

    for (genvar b = 0; b < nb; b++) begin : g_bank
        assert property (@(posedge clk) disable iff (reset) gv_bank[b] |=> bank_valid[b])
            else $error("bank %0d missed a command", b);
        assert property (@(posedge clk) disable iff (reset) bank_valid[b] |-> $past(gv_bank[b]))
            else $error("bank %0d valid without a grant-valid", b);
        assert property (@(posedge clk) disable iff (reset) grant_bank[b] |-> !held[b])
            else $error("bank %0d granted twice without release", b);
    end

    assert property (@(posedge clk) reset |=> (bank_valid == '0 && grants == '0))
        else $error("outputs not cleared by reset");

endmodule

bind output_bus_arbiter output_bus_arbiter_props output_bus_arbiter_props_inst (
    .clk            (clk),
    .reset          (reset),
    .pe_grant_valid (pe_grant_valid),
    .pe_node_id     (pe_node_id),
    .eb_grant_valid (eb_grant_valid),
    .eb_eos         (eb_eos),
    .eb_node_id     (eb_node_id),
    .vb_grant_valid (vb_grant_valid),
    .vb_eos         (vb_eos),
    .vb_node_id     (vb_node_id),
    .bank_eos       (bank_eos),
    .bank_valid     (bank_valid),
    .grants         (grants)
);

`default_nettype wire

/* tests/output_bus_arbiter_tb.sv */
`default_nettype none

module output_bus_arbiter_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int np = output_bus_pkg::num_edge_pe;
    localparam int nvu = output_bus_pkg::num_vertex_unit;
    localparam int nb = output_bus_pkg::num_banks;
    localparam int nr = output_bus_pkg::num_reqs;
    localparam int nw = output_bus_pkg::node_id_w;
    localparam int dw = output_bus_pkg::data_w;
    localparam int max_cycles = 2000;

    logic clk;
    logic reset;
    logic [np-1:0] pe_grant_valid;
    logic [np-1:0][output_bus_pkg::pe_tag_w-1:0] pe_tag;
    logic [np-1:0] pe_req;
    logic [np-1:0][nw-1:0] pe_node_id;
    logic [np-1:0] eb_grant_valid;
    logic [np-1:0] eb_sos;
    logic [np-1:0] eb_eos;
    logic [np-1:0][dw-1:0] eb_data;
    logic [np-1:0] eb_req;
    logic [np-1:0][nw-1:0] eb_node_id;
    logic [nvu-1:0] vb_grant_valid;
    logic [nvu-1:0] vb_sos;
    logic [nvu-1:0] vb_eos;
    logic [nvu-1:0][dw-1:0] vb_data;
    logic [nvu-1:0] vb_req;
    logic [nvu-1:0][nw-1:0] vb_node_id;
    logic [nb-1:0] bank_eos;
    logic [nb-1:0] bank_valid;
    logic [nb-1:0][output_bus_pkg::pe_tag_w-1:0] bank_pe_tag;
    logic [nb-1:0] bank_rd_wr;
    logic [nb-1:0][nw-1:0] bank_node_id;
    logic [nb-1:0][dw-1:0] bank_data;
    logic [nb-1:0] bank_wr_sos;
    logic [nb-1:0] bank_wr_eos;
    logic [nr-1:0] grants;

    int errors = 0;
    int cycles = 0;
    int rr_ptr = 0;
    logic [31:0] seed;

    output_bus_arbiter output_bus_arbiter_inst (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("ERR %0t: %s", $time, what);
        end
    endtask

    function automatic logic [dw-1:0] rand_word();
        return $random(seed);
    endfunction

    // random node id whose low bits pick the given bank
    function automatic logic [nw-1:0] rand_node(input int bank);
        logic [31:0] r;
        r = $random(seed);
        return {r[nw-1:2], 2'(bank)};
    endfunction

    task automatic set_req(input int idx, input logic val, input logic [nw-1:0] nid);
        if (idx < np) begin
            pe_req[idx] <= val;
            pe_node_id[idx] <= nid;
        end else if (idx < 2 * np) begin
            eb_req[idx - np] <= val;
            eb_node_id[idx - np] <= nid;
        end else begin
            vb_req[idx - 2 * np] <= val;
            vb_node_id[idx - 2 * np] <= nid;
        end
    endtask

    task automatic wait_grant(input int idx, output logic seen);
        seen = 1'b0;
        for (int k = 0; k < 20 && !seen; k++) begin
            @(negedge clk);
            seen = grants[idx];
        end
        if (!seen) begin
            errors++;
            $display("requester %0d was never granted", idx);
        end
    endtask

    task automatic pulse_bank_eos(input logic [nb-1:0] banks);
        @(posedge clk);
        bank_eos <= banks;
        @(posedge clk);
        bank_eos <= '0;
    endtask

    // first pending index at or after the round-robin pointer
    function automatic int next_index(input logic [nr-1:0] pending);
        int c;
        for (int k = 0; k < nr; k++) begin
            c = (rr_ptr + k) % nr;
            if (pending[c]) begin
                return c;
            end
        end
        return -1;
    endfunction

    task automatic test_reset();
        @(negedge clk);
        check(bank_valid == '0 && grants == '0,
              $sformatf("after reset bank_valid %h grants %h", bank_valid, grants));
    endtask

    task automatic test_read_routing();
        logic [31:0] r;
        logic [nw-1:0] nid;
        logic [nb-1:0] exp_valid;
        int b;
        for (int i = 0; i < np; i++) begin
            r = rand_word();
            b = int'(r[1:0]);
            nid = rand_node(b);
            exp_valid = '0;
            exp_valid[b] = 1'b1;
            @(posedge clk);
            pe_grant_valid[i] <= 1'b1;
            pe_tag[i] <= 2'(i);
            pe_node_id[i] <= nid;
            @(posedge clk);
            pe_grant_valid[i] <= 1'b0;
            @(negedge clk);
            check(bank_valid == exp_valid,
                  $sformatf("read pe %0d bank_valid %h, expected %h", i, bank_valid, exp_valid));
            check(bank_rd_wr[b] == 1'b0 && bank_pe_tag[b] == 2'(i) && bank_node_id[b] == nid,
                  $sformatf("read pe %0d wrong tag %0d or node %h", i, bank_pe_tag[b],
                            bank_node_id[b]));
            check(bank_data[b] == '0 && !bank_wr_sos[b] && !bank_wr_eos[b],
                  $sformatf("read pe %0d carries write fields", i));
        end
    endtask

    // edge-bank stream e with sos, vertex-bank stream v with eos
    task automatic drive_pair(input int e, input int v, input logic [nw-1:0] e_node,
                              input logic [dw-1:0] e_data, input logic [nw-1:0] v_node,
                              input logic [dw-1:0] v_data);
        @(posedge clk);
        eb_grant_valid[e] <= 1'b1;
        eb_sos[e] <= 1'b1;
        eb_data[e] <= e_data;
        eb_node_id[e] <= e_node;
        vb_grant_valid[v] <= 1'b1;
        vb_eos[v] <= 1'b1;
        vb_data[v] <= v_data;
        vb_node_id[v] <= v_node;
        @(posedge clk);
        eb_grant_valid[e] <= 1'b0;
        eb_sos[e] <= 1'b0;
        vb_grant_valid[v] <= 1'b0;
        vb_eos[v] <= 1'b0;
        @(negedge clk);
    endtask

    task automatic test_write_routing();
        logic [dw-1:0] d0;
        logic [dw-1:0] d1;
        d0 = rand_word();
        d1 = rand_word();
        drive_pair(0, 1, rand_node(1), d0, rand_node(2), d1);
        check(bank_valid == 4'b0110, $sformatf("write bank_valid %h", bank_valid));
        check(bank_rd_wr[1] && bank_data[1] == d0 && bank_wr_sos[1] && !bank_wr_eos[1]
              && bank_pe_tag[1] == '0, $sformatf("edge-bank write data %h", bank_data[1]));
        check(bank_rd_wr[2] && bank_data[2] == d1 && !bank_wr_sos[2] && bank_wr_eos[2],
              $sformatf("vertex-bank write data %h", bank_data[2]));
        d0 = rand_word();
        d1 = rand_word();
        drive_pair(2, 3, rand_node(3), d0, rand_node(3), d1);
        check(bank_valid == 4'b1000, $sformatf("collision bank_valid %h", bank_valid));
        check(bank_data[3] == d1 && bank_wr_eos[3] && !bank_wr_sos[3],
              $sformatf("collision data %h, expected %h", bank_data[3], d1));
    endtask

    task automatic test_round_robin();
        int idx[4] = '{1, 5, 8, 11};
        logic [nr-1:0] pending;
        logic [nr-1:0] granted;
        logic [nr-1:0] exp_grant;
        logic seen;
        int exp_idx;
        int steps;
        // a lone grant at index 6 moves the pointer off zero
        @(posedge clk);
        set_req(6, 1'b1, rand_node(0));
        wait_grant(6, seen);
        rr_ptr = 7;
        @(posedge clk);
        set_req(6, 1'b0, '0);
        pulse_bank_eos(4'b0001);
        pending = '0;
        @(posedge clk);
        for (int k = 0; k < 4; k++) begin
            set_req(idx[k], 1'b1, rand_node(k));
            pending[idx[k]] = 1'b1;
        end
        steps = 0;
        while (pending != '0 && steps < 20) begin
            @(negedge clk);
            steps++;
            if (grants != '0) begin
                granted = grants;
                exp_idx = next_index(pending);
                exp_grant = '0;
                exp_grant[exp_idx] = 1'b1;
                check(granted == exp_grant,
                      $sformatf("grants %h, expected %h", granted, exp_grant));
                rr_ptr = (exp_idx + 1) % nr;
                @(posedge clk);
                for (int i = 0; i < nr; i++) begin
                    if (granted[i]) begin
                        set_req(i, 1'b0, '0);
                        pending[i] = 1'b0;
                    end
                end
            end
        end
        if (pending != '0) begin
            errors++;
            $display("round robin left requests %h ungranted", pending);
        end
        repeat (4) begin
            @(negedge clk);
            check(grants == '0, $sformatf("extra grant %h", grants));
        end
        pulse_bank_eos('1);
    endtask

    task automatic hold_off(input int idx);
        repeat (6) begin
            @(negedge clk);
            check(!grants[idx], $sformatf("requester %0d granted on a busy bank", idx));
        end
    endtask

    task automatic test_busy_release();
        logic seen;
        @(posedge clk);
        set_req(0, 1'b1, rand_node(2));
        wait_grant(0, seen);
        @(posedge clk);
        set_req(0, 1'b0, '0);
        set_req(2, 1'b1, rand_node(2));
        hold_off(2);
        pulse_bank_eos(4'b0100);
        wait_grant(2, seen);
        @(posedge clk);
        set_req(2, 1'b0, '0);
        set_req(3, 1'b1, rand_node(2));
        hold_off(3);
        // release through a vertex stream eos instead
        @(posedge clk);
        vb_eos[0] <= 1'b1;
        vb_node_id[0] <= rand_node(2);
        @(posedge clk);
        vb_eos[0] <= 1'b0;
        wait_grant(3, seen);
        @(posedge clk);
        set_req(3, 1'b0, '0);
        pulse_bank_eos(4'b0100);
    endtask

    initial begin
        seed = 32'h4acc;
        clk = 1'b0;
        reset = 1'b1;
        pe_grant_valid = '0;
        pe_tag = '0;
        pe_req = '0;
        pe_node_id = '0;
        eb_grant_valid = '0;
        eb_sos = '0;
        eb_eos = '0;
        eb_data = '0;
        eb_req = '0;
        eb_node_id = '0;
        vb_grant_valid = '0;
        vb_sos = '0;
        vb_eos = '0;
        vb_data = '0;
        vb_req = '0;
        vb_node_id = '0;
        bank_eos = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_read_routing();
        test_write_routing();
        test_round_robin();
        test_busy_release();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
